/* hdl/audio_pkg.sv */
`default_nettype none

package audio_pkg;

	// FM sample width, stereo sum from the synthesizer
	localparam int fm_w = 16;
	// PSG sample width
	localparam int psg_w = 11;
	// Output and held level width
	localparam int mix_w = 16;

	// FM gain of 22.25 split into integer and quarter parts
	localparam int fm_gain_int = 22;
	localparam int fm_gain_frac_shift = 2;

	// PSG loses 1/32 of itself
	localparam int psg_atten_shift = 5;
	// Brings 11-bit PSG up to 16-bit range
	localparam int psg_align_shift = 5;

	// Clocks per mix tick, same rate as the FM clock enable
	localparam int mix_div = 7;

	// FM source port, req with its sample
	typedef struct packed {
		logic req;
		logic signed [fm_w-1:0] sample;
	} fm_port_t;

	// PSG source port
	typedef struct packed {
		logic req;
		logic signed [psg_w-1:0] sample;
	} psg_port_t;

	// Mixed output stream
	typedef struct packed {
		logic valid;
		logic signed [mix_w-1:0] sample;
	} mix_out_t;

	// Four-phase receiver states
	typedef enum logic [1:0] {
		idle,
		acked,
		wait_release
	} port_state_e;

endpackage

`default_nettype wire

/* hdl/fm_gain_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_gain_stage (
	input wire clk_sys,
	input wire rst_n,
	input wire audio_pkg::fm_port_t fm_in,
	output logic fm_ack,
	output logic signed [audio_pkg::mix_w-1:0] fm_level
);

	audio_pkg::port_state_e state;

	logic signed [audio_pkg::fm_w-1:0] fm_s;
	logic signed [31:0] fm_ext;
	logic signed [31:0] fm_wide;
	logic fm_ovf;
	logic signed [audio_pkg::mix_w-1:0] fm_sat;

	// Incoming sample, stable while req is high
	assign fm_s = fm_in.sample;

	// Sign extend to 32 bits before the gain
	assign fm_ext = {{(32 - audio_pkg::fm_w){fm_s[audio_pkg::fm_w-1]}}, fm_s};

	// Times 22 plus a quarter, arithmetic shift keeps the sign
	assign fm_wide = fm_ext * audio_pkg::fm_gain_int
		+ (fm_ext >>> audio_pkg::fm_gain_frac_shift);

	// Upper bits must all copy the 16-bit sign bit
	assign fm_ovf = (fm_wide[31:audio_pkg::mix_w-1]
		!= {(33 - audio_pkg::mix_w){fm_wide[31]}});

	// Clamp to the signed 16-bit range
	always_comb begin
		if (!fm_ovf) begin
			fm_sat = fm_wide[audio_pkg::mix_w-1:0];
		end else if (fm_wide[31]) begin
			// Most negative value
			fm_sat = {1'b1, {(audio_pkg::mix_w - 1){1'b0}}};
		end else begin
			// Most positive value
			fm_sat = {1'b0, {(audio_pkg::mix_w - 1){1'b1}}};
		end
	end

	// Handshake FSM and level capture
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= audio_pkg::idle;
			fm_level <= '0;
		end else begin
			case (state)
				audio_pkg::idle: begin
					// Capture on the first edge with req high
					if (fm_in.req) begin
						fm_level <= fm_sat;
						state <= audio_pkg::acked;
					end
				end
				audio_pkg::acked: begin
					// Source may already have dropped req
					state <= fm_in.req ? audio_pkg::wait_release : audio_pkg::idle;
				end
				audio_pkg::wait_release: begin
					if (!fm_in.req) begin
						state <= audio_pkg::idle;
					end
				end
				default: begin
					state <= audio_pkg::idle;
				end
			endcase
		end
	end

	// Ack high in every state past capture
	assign fm_ack = (state != audio_pkg::idle);

	// Ack rises only after req was seen high
	ack_after_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(fm_ack) |-> $past(fm_in.req));

	// Level moves only together with the rising ack
	level_on_ack: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(fm_level) |-> $rose(fm_ack));

endmodule

`default_nettype wire

/* hdl/psg_gain_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module psg_gain_stage (
	input wire clk_sys,
	input wire rst_n,
	input wire audio_pkg::psg_port_t psg_in,
	output logic psg_ack,
	output logic signed [audio_pkg::mix_w-1:0] psg_level
);

	audio_pkg::port_state_e state;

	logic signed [audio_pkg::psg_w-1:0] psg_s;
	logic signed [audio_pkg::psg_w-1:0] psg_atten;
	logic signed [audio_pkg::mix_w-1:0] psg_ext;
	logic signed [audio_pkg::mix_w-1:0] psg_aligned;

	assign psg_s = psg_in.sample;

	// 31/32 of the sample, never leaves the 11-bit range
	assign psg_atten = psg_s - (psg_s >>> audio_pkg::psg_atten_shift);

	// Sign extend up to the mix width
	assign psg_ext = {{(audio_pkg::mix_w - audio_pkg::psg_w){psg_atten[audio_pkg::psg_w-1]}},
		psg_atten};

	// Align to 16 bits, at most 992 * 32 so no clamp
	assign psg_aligned = psg_ext <<< audio_pkg::psg_align_shift;

	// Same four-phase receiver as the FM side
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= audio_pkg::idle;
			psg_level <= '0;
		end else begin
			case (state)
				audio_pkg::idle: begin
					if (psg_in.req) begin
						// Level and ack change on the same edge
						psg_level <= psg_aligned;
						state <= audio_pkg::acked;
					end
				end
				audio_pkg::acked: begin
					state <= psg_in.req ? audio_pkg::wait_release : audio_pkg::idle;
				end
				audio_pkg::wait_release: begin
					// Drop ack one cycle after req falls
					if (!psg_in.req) begin
						state <= audio_pkg::idle;
					end
				end
				default: begin
					state <= audio_pkg::idle;
				end
			endcase
		end
	end

	assign psg_ack = (state != audio_pkg::idle);

	// No ack without a request on the edge before
	ack_after_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(psg_ack) |-> $past(psg_in.req));

endmodule

`default_nettype wire

/* hdl/sound_mixer.sv */
`timescale 1ns/10ps
`default_nettype none

module sound_mixer (
	input wire clk_sys,
	input wire rst_n,
	input wire signed [audio_pkg::mix_w-1:0] fm_level,
	input wire signed [audio_pkg::mix_w-1:0] psg_level,
	output audio_pkg::mix_out_t mix_out
);

	typedef logic [$clog2(audio_pkg::mix_div)-1:0] div_cnt_t;

	div_cnt_t div_cnt;
	logic mix_tick;
	logic signed [audio_pkg::mix_w:0] mix_sum;
	logic signed [audio_pkg::mix_w-1:0] mix_sat;

	// Tick on the last count of each period
	assign mix_tick = (div_cnt == div_cnt_t'(audio_pkg::mix_div - 1));

	// Free running divider from zero at reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= mix_tick ? '0 : div_cnt + div_cnt_t'(1);
		end
	end

	// One extra bit so the sum cannot wrap
	assign mix_sum = {fm_level[audio_pkg::mix_w-1], fm_level}
		+ {psg_level[audio_pkg::mix_w-1], psg_level};

	// Top two bits differ on overflow
	always_comb begin
		if (mix_sum[audio_pkg::mix_w] == mix_sum[audio_pkg::mix_w-1]) begin
			mix_sat = mix_sum[audio_pkg::mix_w-1:0];
		end else if (mix_sum[audio_pkg::mix_w]) begin
			mix_sat = {1'b1, {(audio_pkg::mix_w - 1){1'b0}}};
		end else begin
			mix_sat = {1'b0, {(audio_pkg::mix_w - 1){1'b1}}};
		end
	end

	// Registered output with a single-cycle valid per tick
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mix_out <= '0;
		end else begin
			mix_out.valid <= mix_tick;
			// Sample holds between ticks
			if (mix_tick) begin
				mix_out.sample <= mix_sat;
			end
		end
	end

	// Valid is a one-cycle pulse per tick
	valid_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mix_out.valid |=> !mix_out.valid);

endmodule

`default_nettype wire

/* hdl/audio_mix_top.sv */
`timescale 1ns/10ps
`default_nettype none

module audio_mix_top (
	input wire clk_sys,
	input wire rst_n,
	input wire audio_pkg::fm_port_t fm_in,
	output logic fm_ack,
	input wire audio_pkg::psg_port_t psg_in,
	output logic psg_ack,
	output audio_pkg::mix_out_t mix_out
);

	// Held levels from each gain stage
	logic signed [audio_pkg::mix_w-1:0] fm_level;
	logic signed [audio_pkg::mix_w-1:0] psg_level;

	// FM receiver with 22.25 gain
	fm_gain_stage u_fm_gain_stage (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fm_in(fm_in),
		.fm_ack(fm_ack),
		.fm_level(fm_level)
	);

	// PSG receiver with 31/32 attenuation
	psg_gain_stage u_psg_gain_stage (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.psg_in(psg_in),
		.psg_ack(psg_ack),
		.psg_level(psg_level)
	);

	// Sums both levels once per mix tick
	sound_mixer u_sound_mixer (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fm_level(fm_level),
		.psg_level(psg_level),
		.mix_out(mix_out)
	);

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	// 100 ns period
	localparam int half_period = 50;
	localparam int reset_cycles = 8;

	initial begin
		clk_sys = 1'b0;
		forever #half_period clk_sys = ~clk_sys;
	end

	// Release a quarter period after the last reset edge, away from both clock edges
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		#(half_period / 2);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* test/tb_mix_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mix_checker (
	input wire clk_sys,
	input wire rst_n,
	input wire fm_req,
	input wire fm_ack,
	input wire psg_req,
	input wire psg_ack,
	input wire audio_pkg::mix_out_t mix_out,
	input wire test_go,
	input wire [8*24-1:0] test_name,
	input wire signed [audio_pkg::fm_w-1:0] fm_sample,
	input wire signed [audio_pkg::psg_w-1:0] psg_sample,
	input wire signed [audio_pkg::mix_w-1:0] file_expected,
	output int done_count,
	output int pass_count,
	output int fail_count,
	output int hs_err_count
);

	// Signed 16-bit output range
	localparam int sample_max = 32767;
	localparam int sample_min = -32768;
	// Wait bounds in cycles
	localparam int valid_timeout = 30;
	localparam int reset_timeout = 40;
	localparam int idle_timeout = 4000;

	logic fm_ack_q;
	logic fm_req_q;
	logic psg_ack_q;
	logic psg_req_q;

	function automatic int clamp16(input int value);
		if (value > sample_max) begin
			return sample_max;
		end
		if (value < sample_min) begin
			return sample_min;
		end
		return value;
	endfunction

	// FM times 22.25 clamped, PSG keeps 31/32 then times 32, sum clamped
	function automatic int expected_mix(input int fm, input int psg);
		int fm_level;
		int psg_level;
		fm_level = clamp16(fm * 22 + (fm >>> 2));
		psg_level = (psg - (psg >>> 5)) * 32;
		return clamp16(fm_level + psg_level);
	endfunction

	// Next valid, sampled mid cycle
	task automatic wait_valid(output bit seen);
		int cnt;
		seen = 1'b0;
		cnt = 0;
		while (!seen && cnt < valid_timeout) begin
			@(negedge clk_sys);
			cnt++;
			seen = mix_out.valid;
		end
	endtask

	// Counts move on a rising edge, driver polls on falling ones
	task automatic close_test(input bit ok);
		@(posedge clk_sys);
		if (ok) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		done_count++;
	endtask

	initial begin
		int idle;
		int exp_rule;
		int actual;
		bit ok;
		bit seen;
		logic [8*24-1:0] name_q;

		done_count = 0;
		pass_count = 0;
		fail_count = 0;

		// Reset test, outputs quiet while rst_n is low
		ok = 1'b1;
		idle = 0;
		@(negedge clk_sys);
		while (!rst_n && idle < reset_timeout) begin
			if (fm_ack || psg_ack || mix_out.valid) begin
				$display("reset_state: ack or valid high while rst_n is low");
				ok = 1'b0;
			end
			@(negedge clk_sys);
			idle++;
		end
		if (!rst_n) begin
			$display("reset_state: rst_n still low after %0d cycles", reset_timeout);
			ok = 1'b0;
		end
		// First cycle out of reset
		if (fm_ack || psg_ack || mix_out.valid) begin
			$display("reset_state: ack or valid high right after reset");
			ok = 1'b0;
		end
		wait_valid(seen);
		if (!seen) begin
			$display("reset_state: no mix_out.valid within %0d cycles of reset", valid_timeout);
			ok = 1'b0;
		end else if (int'(mix_out.sample) != 0) begin
			$display("[ERROR] reset_state expected 0 actual %0d", mix_out.sample);
			ok = 1'b0;
		end
		if (ok) begin
			$display("reset_state: ok");
		end
		close_test(ok);

		// One pass per test handed over by the driver
		while (1'b1) begin
			idle = 0;
			while (!test_go && idle < idle_timeout) begin
				@(posedge clk_sys);
				idle++;
			end
			if (!test_go) begin
				$display("checker saw no new test for %0d cycles", idle_timeout);
				fail_count++;
				break;
			end
			name_q = test_name;
			exp_rule = expected_mix(int'(fm_sample), int'(psg_sample));
			ok = 1'b1;
			if (exp_rule != int'(file_expected)) begin
				$display("%0s: stimulus file lists %0d but the gain rules give %0d",
					name_q, file_expected, exp_rule);
				ok = 1'b0;
			end
			// Second valid, so one whole tick has seen both levels
			wait_valid(seen);
			if (seen) begin
				wait_valid(seen);
			end
			if (!seen) begin
				$display("%0s: no mix_out.valid within %0d cycles", name_q, valid_timeout);
				ok = 1'b0;
			end else begin
				actual = int'(mix_out.sample);
				if (actual != exp_rule) begin
					$display("[ERROR] %0s expected %0d actual %0d", name_q, exp_rule, actual);
					ok = 1'b0;
				end else if (ok) begin
					$display("%0s: ok, mix %0d", name_q, actual);
				end
			end
			close_test(ok);
		end
	end

	// Handshake order on both ports, values before the edge
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_err_count = 0;
		end else begin
			if (fm_ack && !fm_ack_q && !fm_req_q) begin
				$display("FM ack rose without a request on the edge before");
				hs_err_count++;
			end
			if (!fm_ack && fm_ack_q && fm_req_q) begin
				$display("FM ack fell while req was still high");
				hs_err_count++;
			end
			if (psg_ack && !psg_ack_q && !psg_req_q) begin
				$display("PSG ack rose without a request on the edge before");
				hs_err_count++;
			end
			if (!psg_ack && psg_ack_q && psg_req_q) begin
				$display("PSG ack fell while req was still high");
				hs_err_count++;
			end
		end
		fm_ack_q = fm_ack;
		fm_req_q = fm_req;
		psg_ack_q = psg_ack;
		psg_req_q = psg_req;
	end

endmodule

`default_nettype wire

/* test/tb_audio_mix.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_audio_mix;

	// Wait bounds in cycles
	localparam int hs_timeout = 16;
	localparam int reset_timeout = 40;
	localparam int check_timeout = 80;

	logic clk_sys;
	logic rst_n;
	audio_pkg::fm_port_t fm_in;
	audio_pkg::psg_port_t psg_in;
	logic fm_ack;
	logic psg_ack;
	audio_pkg::mix_out_t mix_out;

	// Hand-off to the checker
	logic test_go;
	logic [8*24-1:0] test_name;
	logic signed [audio_pkg::fm_w-1:0] fm_sample;
	logic signed [audio_pkg::psg_w-1:0] psg_sample;
	logic signed [audio_pkg::mix_w-1:0] file_expected;
	int done_count;
	int pass_count;
	int fail_count;
	int hs_err_count;
	bit aborted;

	tb_clock_gen u_clock_gen (
		.clk_sys(clk_sys),
		.rst_n(rst_n)
	);

	audio_mix_top UUT (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fm_in(fm_in),
		.fm_ack(fm_ack),
		.psg_in(psg_in),
		.psg_ack(psg_ack),
		.mix_out(mix_out)
	);

	tb_mix_checker u_mix_checker (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.fm_req(fm_in.req),
		.fm_ack(fm_ack),
		.psg_req(psg_in.req),
		.psg_ack(psg_ack),
		.mix_out(mix_out),
		.test_go(test_go),
		.test_name(test_name),
		.fm_sample(fm_sample),
		.psg_sample(psg_sample),
		.file_expected(file_expected),
		.done_count(done_count),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.hs_err_count(hs_err_count)
	);

	// Full four-phase cycle on one port from a falling edge
	task automatic run_handshake(input bit is_fm, input int value);
		int wait_cnt;
		if (is_fm) begin
			fm_in.sample = value[audio_pkg::fm_w-1:0];
			fm_in.req = 1'b1;
		end else begin
			psg_in.sample = value[audio_pkg::psg_w-1:0];
			psg_in.req = 1'b1;
		end
		wait_cnt = 0;
		while (!(is_fm ? fm_ack : psg_ack) && wait_cnt < hs_timeout) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (!(is_fm ? fm_ack : psg_ack)) begin
			$display("%s ack did not rise within %0d cycles of req", is_fm ? "FM" : "PSG",
				hs_timeout);
			aborted = 1'b1;
		end
		// Drop req once ack is seen
		if (is_fm) begin
			fm_in.req = 1'b0;
		end else begin
			psg_in.req = 1'b0;
		end
		wait_cnt = 0;
		while ((is_fm ? fm_ack : psg_ack) && wait_cnt < hs_timeout) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (is_fm ? fm_ack : psg_ack) begin
			$display("%s ack did not fall within %0d cycles of req low", is_fm ? "FM" : "PSG",
				hs_timeout);
			aborted = 1'b1;
		end
	endtask

	initial begin
		int fd;
		int code;
		int fm_v;
		int psg_v;
		int order_v;
		int exp_v;
		int wait_cnt;
		int target;
		bit fm_first;
		string line;
		logic [8*24-1:0] name_bits;

		fm_in = '0;
		psg_in = '0;
		test_go = 1'b0;
		test_name = '0;
		fm_sample = '0;
		psg_sample = '0;
		file_expected = '0;
		aborted = 1'b0;
		fd = 0;
		void'($urandom(67));

		fd = $fopen("test/audio_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open test/audio_stimulus.txt");
			aborted = 1'b1;
		end

		// Out of reset and past the checker's reset test
		wait_cnt = 0;
		while ((rst_n !== 1'b1 || done_count < 1) && wait_cnt < reset_timeout) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (done_count < 1) begin
			$display("reset test did not finish within %0d cycles", reset_timeout);
			aborted = 1'b1;
		end

		while (!aborted) begin
			code = $fgets(line, fd);
			if (code == 0) begin
				break;
			end
			// Blank and comment lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			code = $sscanf(line, "%s %d %d %d %d", name_bits, fm_v, psg_v, order_v,
				exp_v);
			if (code != 5) begin
				$display("malformed stimulus line: %s", line);
				aborted = 1'b1;
				break;
			end
			// Order 0 runs FM first and order 1 runs PSG first
			// Any other order is a coin toss
			case (order_v)
				0: fm_first = 1'b1;
				1: fm_first = 1'b0;
				default: fm_first = ($urandom % 2) == 0;
			endcase
			@(negedge clk_sys);
			run_handshake(fm_first, fm_first ? fm_v : psg_v);
			run_handshake(!fm_first, fm_first ? psg_v : fm_v);
			if (aborted) begin
				break;
			end
			target = done_count + 1;
			test_name = name_bits;
			fm_sample = fm_v[audio_pkg::fm_w-1:0];
			psg_sample = psg_v[audio_pkg::psg_w-1:0];
			file_expected = exp_v[audio_pkg::mix_w-1:0];
			test_go = 1'b1;
			@(negedge clk_sys);
			test_go = 1'b0;
			wait_cnt = 0;
			while (done_count < target && wait_cnt < check_timeout) begin
				@(negedge clk_sys);
				wait_cnt++;
			end
			if (done_count < target) begin
				$display("checker did not finish %0s within %0d cycles", name_bits,
					check_timeout);
				aborted = 1'b1;
			end
		end

		if (fd != 0) begin
			$fclose(fd);
		end
		$display("Tests: %0d run, %0d passed, %0d failed, %0d handshake errors",
			done_count, pass_count, fail_count, hs_err_count);
		if (!aborted && fail_count == 0 && hs_err_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/audio_stimulus.txt */
# name fm_sample psg_sample order expected_mix, all values decimal
# order: 0 FM port first, 1 PSG port first, 2 random
zero_inputs 0 0 0 0
fm_one 1 0 0 22
fm_neg_one -1 0 0 -23
fm_small_pos 100 0 0 2225
fm_small_neg -7 0 0 -156
fm_fit_max 1472 0 0 32752
fm_sat_pos 1473 0 0 32767
fm_sat_neg -1473 0 0 -32768
fm_full_pos 32767 0 1 32767
fm_full_neg -32768 0 1 -32768
psg_max 0 1023 1 31744
psg_min 0 -1024 1 -31744
psg_small -7 33 0 868
mix_opposite 100 -100 0 -847
sum_sat_pos 1000 1023 0 32767
sum_sat_neg -1000 -1024 1 -32768
sum_near_limit 1472 1 0 32767
random_pos 300 500 2 22195
random_neg -300 -500 2 -22163
random_small 50 7 2 1336

/* build.f */
hdl/audio_pkg.sv
hdl/fm_gain_stage.sv
hdl/psg_gain_stage.sv
hdl/sound_mixer.sv
hdl/audio_mix_top.sv
test/tb_clock_gen.sv
test/tb_mix_checker.sv
test/tb_audio_mix.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the audio mix testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_audio_mix -f build.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_audio_mix)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '*** PASSED ***'; then
	exit 0
fi
exit 1
